// File: design/ringPkg.sv
// shared constants and types for the ring switch
// flit layout, ring size and utilization window

package ringPkg;

	// routers on the ring
	localparam int NodeCount = 7;

	// bits needed for a node ID
	localparam int NodeIdWidth = 3;

	// payload carried below the exit field
	localparam int PayloadWidth = 32;

	// exit field on top, payload in the low bits
	localparam int DataWidth = NodeIdWidth + PayloadWidth;

	// utilization result width, saturates at all ones
	localparam int UtilWidth = 8;

	// cycles per utilization window
	localparam int UtilWindow = 256;

	// one node ID
	typedef logic [NodeIdWidth-1:0] nodeId_t;

	// one flit word
	typedef logic [DataWidth-1:0] flit_t;

endpackage

// File: design/slotFifo.sv
// synchronous circular FIFO for flits
// hasRoom keeps one spare entry for a write already in flight

`timescale 1ns/1ps

module slotFifo #(
	parameter int Depth = 8
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           push,
	input  logic           pop,
	input  ringPkg::flit_t pushData,
	output ringPkg::flit_t popData,
	output logic           notEmpty,
	output logic           hasRoom
);
	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	ringPkg::flit_t mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic doPush;
	logic doPop;

	assign notEmpty = (count != '0);
	// two free entries needed, one may already be on the wire
	assign hasRoom = (int'(count) <= Depth - 2);
	assign doPush = push && (int'(count) < Depth);
	assign doPop = pop && notEmpty;
	assign popData = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: design/routeCompute.sv
// direction choice for a freshly injected flit
// shortest way round the ring from this node

`timescale 1ns/1ps

module routeCompute #(
	parameter int SrcId = 0
) (
	input  ringPkg::nodeId_t exitNode,
	output logic             toEject,
	output logic             toClockwise
);
	// at most this many hops go clockwise
	localparam int HalfRing = (ringPkg::NodeCount - 1) / 2;

	int hops;

	// clockwise hop count, always non-negative before the modulo
	always_comb begin
		hops = (int'(exitNode) + ringPkg::NodeCount - SrcId) % ringPkg::NodeCount;
	end

	assign toEject = (hops == 0);

	// ties cannot happen on an odd ring
	assign toClockwise = (hops >= 1) && (hops <= HalfRing);

endmodule

// File: design/utilCounter.sv
// windowed event counter
// count saturates, result held for the whole next window

`timescale 1ns/1ps

module utilCounter (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            countEvent,
	output logic [ringPkg::UtilWidth-1:0]   util
);
	localparam int WindowWidth = $clog2(ringPkg::UtilWindow);
	localparam logic [ringPkg::UtilWidth-1:0] CountMax = '1;

	logic [WindowWidth-1:0] windowCnt;
	logic [ringPkg::UtilWidth-1:0] eventCnt;
	logic [ringPkg::UtilWidth-1:0] eventNext;
	logic windowEnd;

	assign windowEnd = (windowCnt == WindowWidth'(ringPkg::UtilWindow - 1));

	// includes the event of the current cycle
	assign eventNext = (countEvent && (eventCnt != CountMax)) ? eventCnt + 1'b1 : eventCnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			windowCnt <= '0;
			eventCnt <= '0;
			util <= '0;
		end else begin
			windowCnt <= windowEnd ? '0 : windowCnt + 1'b1;
			if (windowEnd) begin
				// publish and start the next window empty
				util <= eventNext;
				eventCnt <= '0;
			end else begin
				eventCnt <= eventNext;
			end
		end
	end

endmodule

// File: design/ringRouter.sv
// one ring node: inject and ring input FIFOs, route choice,
// round-robin eject arbiter, transit-first ring outputs
// and utilization counters for both ring outputs and inject

`timescale 1ns/1ps

module ringRouter #(
	parameter int SrcId = 0,
	parameter int InterNodeFifoDepth = 8,
	parameter int IntraNodeFifoDepth = 2
) (
	input  logic                          clk,
	input  logic                          reset,
	input  ringPkg::flit_t                inject,
	input  logic                          injectReceive,
	input  ringPkg::flit_t                ClockwiseIn,
	input  ringPkg::flit_t                CounterClockwiseIn,
	input  logic                          ClockwiseReceive,
	input  logic                          CounterClockwiseReceive,
	input  logic                          ClockwiseNextSlotAvail,
	input  logic                          CounterClockwiseNextSlotAvail,
	input  logic                          EjectSlotAvail,
	output ringPkg::flit_t                ClockwiseOut,
	output ringPkg::flit_t                CounterClockwiseOut,
	output ringPkg::flit_t                eject,
	output logic                          ClockwiseSend,
	output logic                          CounterClockwiseSend,
	output logic                          ejectSend,
	output logic                          ClockwiseSlotAvail,
	output logic                          CounterClockwiseSlotAvail,
	output logic                          InjectSlotAvail,
	output logic [ringPkg::UtilWidth-1:0] ClockwiseUtil,
	output logic [ringPkg::UtilWidth-1:0] CounterClockwiseUtil,
	output logic [ringPkg::UtilWidth-1:0] InjectUtil
);
	localparam ringPkg::nodeId_t MyId = ringPkg::nodeId_t'(SrcId);
	localparam int ExitLsb = ringPkg::PayloadWidth;

	ringPkg::flit_t injData, cwData, ccwData;
	logic injNotEmpty, cwNotEmpty, ccwNotEmpty;
	logic injPop, cwPop, ccwPop;
	logic injToEject, injToClockwise;
	logic injEject, injCw, injCcw;
	logic cwEject, cwTransit, ccwEject, ccwTransit;
	logic cwTakeTransit, cwTakeInject, ccwTakeTransit, ccwTakeInject;
	// bit 0 clockwise head, bit 1 counter-clockwise head, bit 2 inject head
	logic [2:0] ejectReq, ejectGrant;
	logic [1:0] lastGrant;

	slotFifo #(.Depth(IntraNodeFifoDepth)) uInjectFifo (
		.clk(clk), .reset(reset), .push(injectReceive), .pop(injPop),
		.pushData(inject), .popData(injData),
		.notEmpty(injNotEmpty), .hasRoom(InjectSlotAvail)
	);

	slotFifo #(.Depth(InterNodeFifoDepth)) uClockwiseFifo (
		.clk(clk), .reset(reset), .push(ClockwiseReceive), .pop(cwPop),
		.pushData(ClockwiseIn), .popData(cwData),
		.notEmpty(cwNotEmpty), .hasRoom(ClockwiseSlotAvail)
	);

	slotFifo #(.Depth(InterNodeFifoDepth)) uCounterClockwiseFifo (
		.clk(clk), .reset(reset), .push(CounterClockwiseReceive), .pop(ccwPop),
		.pushData(CounterClockwiseIn), .popData(ccwData),
		.notEmpty(ccwNotEmpty), .hasRoom(CounterClockwiseSlotAvail)
	);

	// only injected flits pick a direction, transit keeps its own
	routeCompute #(.SrcId(SrcId)) uRoute (
		.exitNode(injData[ExitLsb +: ringPkg::NodeIdWidth]),
		.toEject(injToEject),
		.toClockwise(injToClockwise)
	);

	assign injEject = injNotEmpty && injToEject;
	assign injCw = injNotEmpty && !injToEject && injToClockwise;
	assign injCcw = injNotEmpty && !injToEject && !injToClockwise;
	assign cwEject = cwNotEmpty && (cwData[ExitLsb +: ringPkg::NodeIdWidth] == MyId);
	assign cwTransit = cwNotEmpty && !cwEject;
	assign ccwEject = ccwNotEmpty && (ccwData[ExitLsb +: ringPkg::NodeIdWidth] == MyId);
	assign ccwTransit = ccwNotEmpty && !ccwEject;

	// ring outputs, transit before inject
	assign cwTakeTransit = cwTransit && ClockwiseNextSlotAvail;
	assign cwTakeInject = injCw && !cwTransit && ClockwiseNextSlotAvail;
	assign ccwTakeTransit = ccwTransit && CounterClockwiseNextSlotAvail;
	assign ccwTakeInject = injCcw && !ccwTransit && CounterClockwiseNextSlotAvail;

	assign ejectReq = {injEject, ccwEject, cwEject} & {3{EjectSlotAvail}};

	// round robin, search starts after the last winner
	always_comb begin
		int idx;
		logic found;
		ejectGrant = '0;
		found = 1'b0;
		for (int i = 1; i <= 3; i++) begin
			idx = (int'(lastGrant) + i) % 3;
			if (!found && ejectReq[idx]) begin
				ejectGrant[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign cwPop = ejectGrant[0] || cwTakeTransit;
	assign ccwPop = ejectGrant[1] || ccwTakeTransit;
	assign injPop = ejectGrant[2] || cwTakeInject || ccwTakeInject;

	always_ff @(posedge clk) begin
		if (reset) begin
			ClockwiseSend <= 1'b0;
			CounterClockwiseSend <= 1'b0;
			ejectSend <= 1'b0;
			lastGrant <= 2'd2;
		end else begin
			ClockwiseSend <= cwTakeTransit || cwTakeInject;
			CounterClockwiseSend <= ccwTakeTransit || ccwTakeInject;
			ejectSend <= |ejectGrant;
			if (|ejectGrant) begin
				lastGrant <= ejectGrant[0] ? 2'd0 : (ejectGrant[1] ? 2'd1 : 2'd2);
			end
		end
	end

	// flit registers, qualified by the send pulses
	always_ff @(posedge clk) begin
		if (cwTakeTransit) begin
			ClockwiseOut <= cwData;
		end else if (cwTakeInject) begin
			ClockwiseOut <= injData;
		end
		if (ccwTakeTransit) begin
			CounterClockwiseOut <= ccwData;
		end else if (ccwTakeInject) begin
			CounterClockwiseOut <= injData;
		end
		if (ejectGrant[0]) begin
			eject <= cwData;
		end else if (ejectGrant[1]) begin
			eject <= ccwData;
		end else if (ejectGrant[2]) begin
			eject <= injData;
		end
	end

	utilCounter uClockwiseUtil (
		.clk(clk), .reset(reset), .countEvent(ClockwiseSend), .util(ClockwiseUtil)
	);

	utilCounter uCounterClockwiseUtil (
		.clk(clk), .reset(reset), .countEvent(CounterClockwiseSend),
		.util(CounterClockwiseUtil)
	);

	utilCounter uInjectUtil (
		.clk(clk), .reset(reset), .countEvent(injectReceive), .util(InjectUtil)
	);

endmodule

// File: design/ringSwitch.sv
// seven-node ring switch top
// one router per node ID and the ring links between neighbours

`timescale 1ns/1ps

module ringSwitch #(
	parameter int InterNodeFifoDepth = 8,
	parameter int IntraNodeFifoDepth = 2
) (
	input  logic                          clk,
	input  logic                          reset,
	input  ringPkg::flit_t                inject [ringPkg::NodeCount],
	input  logic                          injectReceive [ringPkg::NodeCount],
	input  logic                          EjectSlotAvail [ringPkg::NodeCount],
	output ringPkg::flit_t                eject [ringPkg::NodeCount],
	output logic                          ejectSend [ringPkg::NodeCount],
	output logic                          InjectSlotAvail [ringPkg::NodeCount],
	output logic [ringPkg::UtilWidth-1:0] ClockwiseUtil [ringPkg::NodeCount],
	output logic [ringPkg::UtilWidth-1:0] CounterClockwiseUtil [ringPkg::NodeCount],
	output logic [ringPkg::UtilWidth-1:0] InjectUtil [ringPkg::NodeCount]
);
	// node map, clockwise goes up in ID
	//   3 +x   2 +y   1 -y
	//   4 -x             0 local
	//   5 +z   6 -z
	// 6 wraps back to 0

	// indexed by the sending node
	ringPkg::flit_t clockwiseData [ringPkg::NodeCount];
	ringPkg::flit_t counterData [ringPkg::NodeCount];
	logic clockwiseSend [ringPkg::NodeCount];
	logic counterSend [ringPkg::NodeCount];

	// indexed by the receiving node
	logic clockwiseAvail [ringPkg::NodeCount];
	logic counterAvail [ringPkg::NodeCount];

	for (genvar n = 0; n < ringPkg::NodeCount; n++) begin : gNode
		localparam int Prev = (n + ringPkg::NodeCount - 1) % ringPkg::NodeCount;
		localparam int Next = (n + 1) % ringPkg::NodeCount;

		ringRouter #(
			.SrcId(n),
			.InterNodeFifoDepth(InterNodeFifoDepth),
			.IntraNodeFifoDepth(IntraNodeFifoDepth)
		) uRouter (
			.clk(clk),
			.reset(reset),
			.inject(inject[n]),
			.injectReceive(injectReceive[n]),
			// clockwise traffic arrives from the previous node
			.ClockwiseIn(clockwiseData[Prev]),
			.ClockwiseReceive(clockwiseSend[Prev]),
			// counter-clockwise traffic arrives from the next node
			.CounterClockwiseIn(counterData[Next]),
			.CounterClockwiseReceive(counterSend[Next]),
			.ClockwiseNextSlotAvail(clockwiseAvail[Next]),
			.CounterClockwiseNextSlotAvail(counterAvail[Prev]),
			.EjectSlotAvail(EjectSlotAvail[n]),
			.ClockwiseOut(clockwiseData[n]),
			.CounterClockwiseOut(counterData[n]),
			.eject(eject[n]),
			.ClockwiseSend(clockwiseSend[n]),
			.CounterClockwiseSend(counterSend[n]),
			.ejectSend(ejectSend[n]),
			.ClockwiseSlotAvail(clockwiseAvail[n]),
			.CounterClockwiseSlotAvail(counterAvail[n]),
			.InjectSlotAvail(InjectSlotAvail[n]),
			.ClockwiseUtil(ClockwiseUtil[n]),
			.CounterClockwiseUtil(CounterClockwiseUtil[n]),
			.InjectUtil(InjectUtil[n])
		);
	end

endmodule

// File: dv/ringSwitch_sva.sv
// flow control and reset checks for one ring router
// bound into every ringRouter instance

`timescale 1ns/1ps

module routerFlowAssertions (
	input logic clk,
	input logic reset,
	input logic injectReceive,
	input logic InjectSlotAvail,
	input logic EjectSlotAvail,
	input logic ejectSend,
	input logic ClockwiseNextSlotAvail,
	input logic CounterClockwiseNextSlotAvail,
	input logic ClockwiseSend,
	input logic CounterClockwiseSend
);
	// failed assertions in this router
	int failCount = 0;

	ejectNeedsSlot: assert property (@(posedge clk) disable iff (reset)
		!EjectSlotAvail |=> !ejectSend)
		else begin
			$error("ejectSend after a cycle without an eject slot");
			failCount++;
		end

	clockwiseNeedsSlot: assert property (@(posedge clk) disable iff (reset)
		!ClockwiseNextSlotAvail |=> !ClockwiseSend)
		else begin
			$error("ClockwiseSend after a cycle without a downstream slot");
			failCount++;
		end

	counterNeedsSlot: assert property (@(posedge clk) disable iff (reset)
		!CounterClockwiseNextSlotAvail |=> !CounterClockwiseSend)
		else begin
			$error("CounterClockwiseSend after a cycle without a downstream slot");
			failCount++;
		end

	// all pulses quiet once reset has been seen
	quietAfterReset: assert property (@(posedge clk)
		reset |=> !ejectSend && !ClockwiseSend && !CounterClockwiseSend)
		else begin
			$error("send pulse in the cycle after reset");
			failCount++;
		end

	injectLegal: assert property (@(posedge clk) disable iff (reset)
		injectReceive |-> InjectSlotAvail)
		else begin
			$error("injectReceive while the inject FIFO had no room");
			failCount++;
		end

endmodule

bind ringRouter routerFlowAssertions uFlowAssertions (.*);

// File: dv/ringSwitchTb.sv
// testbench for the seven-node ring switch
// stimulus table, per-pair scoreboard, utilization model
// and back-pressure phases

`timescale 1ns/1ps

module ringSwitchTb;
	localparam int Nodes = ringPkg::NodeCount;
	localparam int RowCount = 40;
	localparam int WaitLimit = 4000;
	localparam int StallCycles = 40;

	logic clk;
	logic reset;
	ringPkg::flit_t inject [Nodes];
	logic injectReceive [Nodes];
	logic EjectSlotAvail [Nodes];
	ringPkg::flit_t eject [Nodes];
	logic ejectSend [Nodes];
	logic InjectSlotAvail [Nodes];
	logic [ringPkg::UtilWidth-1:0] ClockwiseUtil [Nodes];
	logic [ringPkg::UtilWidth-1:0] CounterClockwiseUtil [Nodes];
	logic [ringPkg::UtilWidth-1:0] InjectUtil [Nodes];

	// hex digits: source, exit, idle gap (2), payload (8)
	logic [47:0] stimTable [RowCount] = '{
		48'h0_0_01_11110000, 48'h1_1_00_11110001, 48'h2_2_00_11110002, 48'h3_3_01_11110003,
		48'h4_4_00_11110004, 48'h5_5_00_11110005, 48'h6_6_02_11110006, 48'h0_3_00_22220007,
		48'h0_4_01_22220008, 48'h1_5_00_22220009, 48'h2_6_00_2222000a, 48'h3_0_03_2222000b,
		48'h4_1_00_2222000c, 48'h5_2_01_2222000d, 48'h6_3_00_2222000e, 48'h0_1_00_2222000f,
		48'h1_0_02_33330010, 48'h2_3_00_33330011, 48'h3_2_00_33330012, 48'h4_5_01_33330013,
		48'h5_4_00_33330014, 48'h6_0_00_33330015, 48'h0_6_03_33330016, 48'h1_4_00_33330017,
		48'h2_5_00_44440018, 48'h3_6_01_44440019, 48'h4_0_00_4444001a, 48'h5_1_00_4444001b,
		48'h6_2_02_4444001c, 48'h0_3_00_4444001d, 48'h0_3_00_4444001e, 48'h1_5_01_4444001f,
		48'h1_5_00_55550020, 48'h2_6_00_55550021, 48'h3_0_00_55550022, 48'h4_1_02_55550023,
		48'h6_3_00_55550024, 48'h5_2_01_55550025, 48'h2_0_00_55550026, 48'h3_5_00_55550027
	};

	// expected flits per source and exit pair, index source * Nodes + exit
	ringPkg::flit_t expQ [Nodes*Nodes][$];
	int outstanding;
	int errorCount;
	int timeoutCount;
	int assertFailTotal;
	int assertFails [Nodes];
	int cycIdx;
	int strobeCnt [Nodes];
	int expUtil [Nodes];
	logic ejectAvailPrev [Nodes];
	logic ejectHold [Nodes];
	logic dipEnable;
	logic checksOn;

	ringSwitch #(
		.InterNodeFifoDepth(8),
		.IntraNodeFifoDepth(2)
	) u_ringSwitch (.*);

	// failures seen by the bound flow checkers
	for (genvar g = 0; g < Nodes; g++) begin : gAssertFails
		assign assertFails[g] = u_ringSwitch.gNode[g].uRouter.uFlowAssertions.failCount;
	end

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// eject back-pressure, random one-cycle dips in phase 2
	initial begin
		void'($urandom(32'hdb70_c0c9));
		forever begin
			@(posedge clk);
			#2;
			for (int n = 0; n < Nodes; n++) begin
				if (ejectHold[n]) begin
					EjectSlotAvail[n] = 1'b0;
				end else if (dipEnable && EjectSlotAvail[n]) begin
					EjectSlotAvail[n] = ($urandom % 4) != 0;
				end else begin
					EjectSlotAvail[n] = 1'b1;
				end
			end
		end
	end

	// reference model of the inject windows, first window starts after reset
	always @(posedge clk) begin
		for (int n = 0; n < Nodes; n++) begin
			ejectAvailPrev[n] = EjectSlotAvail[n];
		end
		if (reset) begin
			cycIdx = 0;
			for (int n = 0; n < Nodes; n++) begin
				strobeCnt[n] = 0;
				expUtil[n] = 0;
			end
		end else begin
			for (int n = 0; n < Nodes; n++) begin
				if (injectReceive[n] && strobeCnt[n] < 255) begin
					strobeCnt[n]++;
				end
				if (cycIdx % ringPkg::UtilWindow == ringPkg::UtilWindow - 1) begin
					expUtil[n] = strobeCnt[n];
					strobeCnt[n] = 0;
				end
			end
			cycIdx++;
		end
	end

	task automatic matchEject(input int node);
		int key;
		bit found;
		found = 1'b0;
		for (int s = 0; s < Nodes; s++) begin
			key = s * Nodes + node;
			if (!found && expQ[key].size() > 0 && expQ[key][0] === eject[node]) begin
				void'(expQ[key].pop_front());
				outstanding--;
				found = 1'b1;
			end
		end
		if (!found) begin
			$display("ERROR %0t: node %0d ejected unexpected or out-of-order flit %h",
				$time, node, eject[node]);
			errorCount++;
		end
	endtask

	// outputs sampled mid-cycle, well away from the clock edge
	always @(negedge clk) begin
		if (checksOn) begin
			for (int n = 0; n < Nodes; n++) begin
				if (ejectSend[n] === 1'b1) begin
					if (!ejectAvailPrev[n]) begin
						$display("ERROR %0t: node %0d ejected without a slot", $time, n);
						errorCount++;
					end
					matchEject(n);
				end
				if (InjectUtil[n] !== ringPkg::UtilWidth'(expUtil[n])) begin
					$display("ERROR %0t: node %0d InjectUtil %0d, expected %0d",
						$time, n, InjectUtil[n], expUtil[n]);
					errorCount++;
				end
				if (cycIdx < ringPkg::UtilWindow &&
						(ClockwiseUtil[n] !== '0 || CounterClockwiseUtil[n] !== '0)) begin
					$display("ERROR %0t: node %0d ring utilization nonzero in first window",
						$time, n);
					errorCount++;
				end
			end
		end
	end

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
		end
	endtask

	// called 2 ns after a rising edge, returns at the same point of a later cycle
	task automatic sendFlit(input int src, input int exitNode,
			input logic [ringPkg::PayloadWidth-1:0] payload);
		int waited;
		ringPkg::flit_t flit;
		waited = 0;
		flit = {ringPkg::NodeIdWidth'(exitNode), payload};
		while (!InjectSlotAvail[src] && waited < WaitLimit) begin
			idle(1);
			waited++;
		end
		if (!InjectSlotAvail[src]) begin
			$display("node %0d inject port never freed up, flit %h not sent", src, flit);
			timeoutCount++;
		end else begin
			inject[src] = flit;
			injectReceive[src] = 1'b1;
			expQ[src * Nodes + exitNode].push_back(flit);
			outstanding++;
			idle(1);
			injectReceive[src] = 1'b0;
		end
	endtask

	task automatic runTable(input logic [ringPkg::PayloadWidth-1:0] salt);
		logic [47:0] row;
		for (int r = 0; r < RowCount; r++) begin
			row = stimTable[r];
			sendFlit(int'(row[47:44]), int'(row[43:40]), row[31:0] ^ salt);
			idle(int'(row[39:32]));
		end
	endtask

	task automatic waitDrain(input string phase);
		int waited;
		waited = 0;
		while (outstanding != 0 && waited < WaitLimit) begin
			idle(1);
			waited++;
		end
		if (outstanding != 0) begin
			$display("%s: timed out with %0d flits still missing", phase, outstanding);
			timeoutCount++;
		end
	endtask

	// fill the path to a blocked exit until the source inject port stalls
	task automatic runBurst(input int src, input int target);
		int stallRun;
		int waited;
		int sent;
		stallRun = 0;
		waited = 0;
		sent = 0;
		ejectHold[target] = 1'b1;
		idle(2);
		while (stallRun < StallCycles && waited < WaitLimit) begin
			if (InjectSlotAvail[src]) begin
				sendFlit(src, target, 32'hb000_0000 + sent);
				sent++;
				stallRun = 0;
			end else begin
				idle(1);
				stallRun++;
			end
			waited++;
		end
		if (stallRun < StallCycles) begin
			$display("burst from node %0d never stalled its inject port", src);
			timeoutCount++;
		end
		ejectHold[target] = 1'b0;
		waitDrain("burst");
	endtask

	// run past the next window edge so the last strobes get published
	task automatic waitWindowEdge();
		int target;
		int waited;
		target = (cycIdx / ringPkg::UtilWindow + 1) * ringPkg::UtilWindow + 4;
		waited = 0;
		while (cycIdx < target && waited < 2 * ringPkg::UtilWindow) begin
			idle(1);
			waited++;
		end
		if (cycIdx < target) begin
			$display("utilization window edge was never reached");
			timeoutCount++;
		end
	endtask

	initial begin
		reset = 1'b1;
		checksOn = 1'b0;
		dipEnable = 1'b0;
		outstanding = 0;
		errorCount = 0;
		timeoutCount = 0;
		for (int n = 0; n < Nodes; n++) begin
			inject[n] = '0;
			injectReceive[n] = 1'b0;
			EjectSlotAvail[n] = 1'b1;
			ejectHold[n] = 1'b0;
			ejectAvailPrev[n] = 1'b1;
		end
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		checksOn = 1'b1;

		// quiet ring right after reset
		repeat (4) begin
			@(negedge clk);
			for (int n = 0; n < Nodes; n++) begin
				if (ejectSend[n] !== 1'b0 || InjectSlotAvail[n] !== 1'b1) begin
					$display("ERROR %0t: node %0d not idle after reset", $time, n);
					errorCount++;
				end
			end
		end
		idle(1);

		runTable('0);
		waitDrain("phase 1");
		dipEnable = 1'b1;
		runTable(32'h5a5a_0000);
		waitDrain("phase 2");
		dipEnable = 1'b0;
		runBurst(1, 4);
		waitWindowEdge();

		assertFailTotal = 0;
		for (int n = 0; n < Nodes; n++) begin
			assertFailTotal += assertFails[n];
		end
		$display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
			errorCount, timeoutCount, assertFailTotal);
		if (errorCount == 0 && timeoutCount == 0 && assertFailTotal == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
design/ringPkg.sv
design/slotFifo.sv
design/routeCompute.sv
design/utilCounter.sv
design/ringRouter.sv
design/ringSwitch.sv
dv/ringSwitch_sva.sv
dv/ringSwitchTb.sv

// File: Bender.yml
package:
  name: ring_switch

dependencies: {}

sources:
  # synthesizable ring switch, package first
  - files:
      - design/ringPkg.sv
      - design/slotFifo.sv
      - design/routeCompute.sv
      - design/utilCounter.sv
      - design/ringRouter.sv
      - design/ringSwitch.sv

  # verification only
  - target: test
    files:
      - dv/ringSwitch_sva.sv
      - dv/ringSwitchTb.sv
